//--- files.f
memGamePkg.sv
screenPkg.sv
memGameRules.sv
memPixelGen.sv
memPixelColor.sv
memGameTop.sv
memGame_checker.sv
memGameTb.sv

//--- Bender.yml
package:
  name: memgame

sources:
  - memGamePkg.sv
  - screenPkg.sv
  - memGameRules.sv
  - memPixelGen.sv
  - memPixelColor.sv
  - memGameTop.sv
  - target: simulation
    files:
      - memGame_checker.sv
      - memGameTb.sv

//--- memGameTb.sv
//****************************************
// testbench for memGameTop
// puzzles are random, seed fixed at start
// labels in a stage form a permutation
// probes rely on the two-cycle pixel lag
//****************************************
`timescale 1ns/1ps

module memGameTb;
    import memGamePkg::*;
    import screenPkg::*;

    logic        clk;
    logic        nrst;
    logic [8:0]  x;
    logic [7:0]  y;
    logic        loadPuzzle;
    memPuzzle    puzzle;
    logic        moveLeft;
    logic        moveRight;
    logic        select;
    logic [15:0] pixelColor;
    logic        strike;
    logic        solved;
    int          cursor;                // expected cursor index
    int          pressPos[numStages];
    int          pressLab[numStages];   // label numbers 1..4
    int          wrongStage;

    memGameTop i_memGameTop (.*);

    task automatic stopWithFail();
        $display("Simulation finished: FAIL");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic failValue(input string msg);
        $display("FAIL %0t: %s", $time, msg);
        stopWithFail();
    endtask

    task automatic failPlain(input string msg);
        $display("%s", msg);
        stopWithFail();
    endtask

    task automatic tick(input int n = 1);
        repeat (n) @(posedge clk);
        #1;
    endtask

    task automatic waitFlag(input bit wantStrike, input string what);
        int n;
        n = 0;
        while (!(wantStrike ? strike : solved) && n < 8) begin
            tick();
            n++;
        end
        if (!(wantStrike ? strike : solved)) failPlain(what);
    endtask

    task automatic pressMove(input bit left);
        moveLeft  = left;
        moveRight = !left;
        tick();
        moveLeft  = 1'b0;
        moveRight = 1'b0;
        if (left && cursor < numButtons - 1) cursor++;   // left means a higher index
        if (!left && cursor > 0) cursor--;
    endtask

    task automatic pressSelect();
        select = 1'b1;
        tick();
        select = 1'b0;
    endtask

    task automatic probe(input int px, input int py, input logic [15:0] want, input string what);
        x = 9'(px);
        y = 8'(py);
        tick(2);
        assert (pixelColor == want)
            else failValue($sformatf("%s at (%0d,%0d) is %h, expected %h",
                                     what, px, py, pixelColor, want));
    endtask

    function automatic int buttonRight(input int i);
        return screenWidth - marginWidth - i * (buttonWidth + space);
    endfunction

    function automatic int buttonWithLabel(input int s, input int lab);
        for (int i = 0; i < numButtons; i++) begin
            if (int'(puzzle.labels[s][i]) + 1 == lab) return i;
        end
        return 0;
    endfunction

    // rule table, d is the shown number 1..4
    function automatic int targetIndex(input int s);
        int d;
        d = int'(puzzle.display[s]) + 1;
        case (s)
            0: return (d <= 2) ? 1 : d - 1;
            1: return (d == 1) ? buttonWithLabel(1, 4) : (d == 3) ? 0 : pressPos[0];
            2: begin
                case (d)
                    1: return buttonWithLabel(2, pressLab[1]);
                    2: return buttonWithLabel(2, pressLab[0]);
                    3: return 2;
                    default: return buttonWithLabel(2, 4);
                endcase
            end
            3: return (d == 1) ? pressPos[0] : (d == 2) ? 0 : pressPos[1];
            default: begin
                case (d)
                    1: return buttonWithLabel(4, pressLab[0]);
                    2: return buttonWithLabel(4, pressLab[1]);
                    3: return buttonWithLabel(4, pressLab[3]);
                    default: return buttonWithLabel(4, pressLab[2]);
                endcase
            end
        endcase
    endfunction

    task automatic loadRandomPuzzle();
        int perm[numButtons];
        int j;
        int t;
        for (int s = 0; s < numStages; s++) begin
            for (int i = 0; i < numButtons; i++) perm[i] = i;
            for (int i = numButtons - 1; i > 0; i--) begin    // shuffle labels
                j = int'($urandom % (i + 1));
                t = perm[i];
                perm[i] = perm[j];
                perm[j] = t;
            end
            puzzle.display[s] = memDigit'($urandom % 4);
            for (int i = 0; i < numButtons; i++) puzzle.labels[s][i] = memDigit'(perm[i]);
        end
        loadPuzzle = 1'b1;
        tick();
        loadPuzzle = 1'b0;
        cursor = 0;
        assert (!solved) else failValue("solved still high after loadPuzzle");
    endtask

    task automatic playStage(input int s, input bit wrong);
        int target;
        target = targetIndex(s);
        if (wrong) target = (target + 1) % numButtons;
        while (cursor != target) pressMove(target > cursor);
        pressPos[s] = target;
        pressLab[s] = int'(puzzle.labels[s][target]) + 1;
        pressSelect();
    endtask

    task automatic solvePuzzle();
        logic [15:0] barColor;
        for (int s = 0; s < numStages; s++) begin
            // middle bar is dark only for the number 1
            barColor = (puzzle.display[s] != 2'd0) ? colDisplay : colBackground;
            probe(displayX - segColNear - 10, lowerY + segRowMid + 2, barColor, "display bar");
            playStage(s, 1'b0);
            assert (!strike) else failValue($sformatf("strike on correct press, stage %0d", s));
        end
        waitFlag(1'b0, "solved did not rise after the fifth correct press");
        probe(buttonRight(0) - 20, 40, colSolved, "solved button face");
    endtask

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(negedge clk) begin
        if (i_memGameTop.i_memGameChecker.failCount != 0) begin
            failPlain("a bound assertion on the DUT ports failed");
        end
    end

    initial begin
        void'($urandom(98858));
        nrst       = 1'b0;
        x          = '0;
        y          = '0;
        loadPuzzle = 1'b0;
        puzzle     = '0;
        moveLeft   = 1'b0;
        moveRight  = 1'b0;
        select     = 1'b0;
        cursor     = 0;
        tick(4);
        nrst = 1'b1;

        assert (!strike && !solved) else failValue("strike or solved high after reset");
        probe(5, 5, colBackground, "corner after reset");

        pressMove(1'b0);    // stays at 0
        probe(buttonRight(0) - 20, marginHeight - 3, colHighlight, "ring at button 0");
        repeat (5) pressMove(1'b1);
        probe(buttonRight(3) - 20, marginHeight - 3, colHighlight, "ring at button 3");
        probe(buttonRight(2) - 20, marginHeight - 3, colBackground, "beside button 2");

        repeat (20) begin
            loadRandomPuzzle();
            solvePuzzle();
        end

        // presses while solved are ignored
        pressMove(cursor < numButtons - 1);     // off the last target
        pressSelect();
        assert (!strike && solved) else failValue("select while solved changed the state");

        repeat (4) begin
            loadRandomPuzzle();
            wrongStage = int'($urandom % numStages);
            for (int s = 0; s < wrongStage; s++) playStage(s, 1'b0);
            playStage(wrongStage, 1'b1);
            waitFlag(1'b1, "no strike after a wrong press");
            probe(buttonRight(3) - 20, lowerY + 5, colStage, "stage light 0");
            probe(buttonRight(3) - 20, lowerY + 25, colBackground, "stage light 1");
            solvePuzzle();
        end

        if (i_memGameTop.i_memGameChecker.failCount != 0) begin
            failPlain("a bound assertion on the DUT ports failed");
        end else begin
            $display("Simulation finished: PASS");
            $finish;
        end
    end

endmodule

//--- memGame_checker.sv
//****************************************
// port assertions for memGameTop
// assumes no two wrong selects in a row
// so strike never lasts two cycles
//****************************************
`timescale 1ns/1ps

module memGameChecker (
    input logic clk,
    input logic nrst,
    input logic loadPuzzle,
    input logic moveLeft,
    input logic moveRight,
    input logic select,
    input logic strike,
    input logic solved
);
    int   failCount = 0;
    logic quiet;    // no input pulse since reset

    always_ff @(posedge clk) begin
        if (!nrst) begin
            quiet <= 1'b1;
        end else if (loadPuzzle || moveLeft || moveRight || select) begin
            quiet <= 1'b0;
        end
    end

    strikeOneCycle: assert property (@(posedge clk) disable iff (!nrst) strike |=> !strike)
        else begin
            $error("strike held for more than one cycle");
            failCount++;
        end

    strikeNotSolved: assert property (@(posedge clk) disable iff (!nrst)
        !(strike && $rose(solved)))
        else begin
            $error("strike together with a solved rise");
            failCount++;
        end

    solvedHolds: assert property (@(posedge clk) disable iff (!nrst)
        solved && !loadPuzzle |=> solved)
        else begin
            $error("solved dropped without loadPuzzle or reset");
            failCount++;
        end

    quietAfterReset: assert property (@(posedge clk) disable iff (!nrst)
        quiet |-> !strike && !solved)
        else begin
            $error("strike or solved before any input pulse");
            failCount++;
        end

endmodule

bind memGameTop memGameChecker i_memGameChecker (
    .clk        (clk),
    .nrst       (nrst),
    .loadPuzzle (loadPuzzle),
    .moveLeft   (moveLeft),
    .moveRight  (moveRight),
    .select     (select),
    .strike     (strike),
    .solved     (solved)
);

//--- memGameTop.sv
//****************************************
// memory game module top
// x and y come from an external scan
// pixelColor lags x and y by two cycles
//****************************************
`timescale 1ns/1ps

module memGameTop (
    input  logic                 clk,
    input  logic                 nrst,
    input  logic [8:0]           x,
    input  logic [7:0]           y,
    input  logic                 loadPuzzle,
    input  memGamePkg::memPuzzle puzzle,
    input  logic                 moveLeft,
    input  logic                 moveRight,
    input  logic                 select,
    output logic [15:0]          pixelColor,
    output logic                 strike,
    output logic                 solved
);
    import memGamePkg::*;
    import screenPkg::*;

    memStatus status;
    memLayers layers;

    memGameRules i_memGameRules (
        .clk        (clk),
        .nrst       (nrst),
        .loadPuzzle (loadPuzzle),
        .puzzle     (puzzle),
        .moveLeft   (moveLeft),
        .moveRight  (moveRight),
        .select     (select),
        .status     (status),
        .strike     (strike)
    );

    memPixelGen i_memPixelGen (
        .clk    (clk),
        .nrst   (nrst),
        .x      (x),
        .y      (y),
        .status (status),
        .layers (layers)
    );

    memPixelColor i_memPixelColor (
        .clk        (clk),
        .nrst       (nrst),
        .layers     (layers),
        .pixelColor (pixelColor)
    );

    assign solved = status.solved;  // level straight from the rules register

endmodule

//--- memPixelColor.sv
//****************************************
// layer merge to one RGB565 colour
// one register stage
// digits over buttons over ring over
// stage lights over background
//****************************************
`timescale 1ns/1ps

module memPixelColor (
    input  logic                clk,
    input  logic                nrst,
    input  screenPkg::memLayers layers,
    output logic [15:0]         pixelColor
);
    import screenPkg::*;

    logic [15:0] nextColor;

    always_comb begin
        if (layers.label != 4'd0) begin
            nextColor = colLabel;
        end else if (layers.display) begin
            nextColor = colDisplay;
        end else if (layers.button) begin
            // whole button face turns when the module is solved
            nextColor = layers.solvedTint ? colSolved : colButton;
        end else if (layers.highlight) begin
            nextColor = colHighlight;
        end else if (layers.stage) begin
            nextColor = colStage;
        end else begin
            nextColor = colBackground;
        end
    end

    always_ff @(posedge clk) begin
        if (!nrst) begin
            pixelColor <= colBackground;
        end else begin
            pixelColor <= nextColor;
        end
    end

endmodule

//--- memPixelGen.sv
//****************************************
// layer hit detection for the memory panel
// one register stage, x and y to layers
// button 0 sits at the right-hand margin
// stage lights use the column of button 3
//****************************************
`timescale 1ns/1ps

module memPixelGen (
    input  logic                 clk,
    input  logic                 nrst,
    input  logic [8:0]           x,
    input  logic [7:0]           y,
    input  memGamePkg::memStatus status,
    output screenPkg::memLayers  layers
);
    import memGamePkg::*;
    import screenPkg::*;

    memLayers hit;
    int       px;
    int       py;

    assign px = int'(x);
    assign py = int'(y);

    // horizontal bar, right end at sco, 5 rows from spo
    function automatic logic hBar(input int cx, input int cy, input int sco, input int spo);
        return (((cy == spo) || (cy == spo + 4)) && (cx <= sco - 2) && (cx >= sco - 17))
            || (((cy == spo + 1) || (cy == spo + 3)) && (cx <= sco - 1) && (cx >= sco - 18))
            || ((cy == spo + 2) && (cx <= sco) && (cx >= sco - 19));
    endfunction

    // vertical bar, 5 columns left of sco, 20 rows from spo
    function automatic logic vBar(input int cx, input int cy, input int sco, input int spo);
        return (((cx == sco) || (cx == sco - 4)) && (cy >= spo + 2) && (cy <= spo + 17))
            || (((cx == sco - 1) || (cx == sco - 3)) && (cy >= spo + 1) && (cy <= spo + 18))
            || ((cx == sco - 2) && (cy >= spo) && (cy <= spo + 19));
    endfunction

    function automatic logic [6:0] digitSegs(input memDigit d);
        case (d)
            2'd0:    return 7'b0000110;    // one
            2'd1:    return 7'b1011011;    // two
            2'd2:    return 7'b1001111;
            2'd3:    return 7'b1100110;
            default: return 7'b0000000;
        endcase
    endfunction

    function automatic logic drawDigit(
        input int         cx,
        input int         cy,
        input int         baseX,
        input int         baseY,
        input logic [6:0] segs
    );
        logic on;
        on = 1'b0;
        if (segs[6]) on |= hBar(cx, cy, baseX - segColNear, baseY + segRowMid);
        if (segs[5]) on |= vBar(cx, cy, baseX - segColNear, baseY + segRowMid);
        if (segs[4]) on |= vBar(cx, cy, baseX - segColNear, baseY + segRowBottom);
        if (segs[3]) on |= hBar(cx, cy, baseX - segColNear, baseY + segRowBottom);
        if (segs[2]) on |= vBar(cx, cy, baseX - segColFar, baseY + segRowBottom);
        if (segs[1]) on |= vBar(cx, cy, baseX - segColFar, baseY + segRowMid);
        if (segs[0]) on |= hBar(cx, cy, baseX - segColNear, baseY + segRowTop);
        return on;
    endfunction

    // right edge of button i
    function automatic int btnRight(input int i);
        return screenWidth - (marginWidth + i * (buttonWidth + space));
    endfunction

    always_comb begin
        hit = '0;

        for (int i = 0; i < numButtons; i++) begin
            if (px < btnRight(i) && px > btnRight(i) - buttonWidth
                && py > marginHeight && py < marginHeight + buttonHeight) begin
                hit.button = 1'b1;
            end
            hit.label[i] = drawDigit(px, py, btnRight(i), marginHeight + labelInset,
                                     digitSegs(status.shownLabels[i]));
        end

        hit.display = drawDigit(px, py, displayX, lowerY, digitSegs(status.shownDigit));

        // ring around the cursor button
        if (px < btnRight(int'(status.cursor)) + ringWidth
            && px > btnRight(int'(status.cursor)) - buttonWidth - ringWidth
            && py > marginHeight - ringWidth
            && py < marginHeight + buttonHeight + ringWidth) begin
            hit.highlight = 1'b1;
        end

        if (px < btnRight(numButtons - 1) && px > btnRight(numButtons - 1) - buttonWidth) begin
            for (int i = 0; i < numStages; i++) begin
                if (i <= int'(status.stage)
                    && py > lowerY + i * (space + space)
                    && py < lowerY + i * (space + space) + space) begin
                    hit.stage = 1'b1;
                end
            end
        end

        hit.solvedTint = status.solved;
    end

    always_ff @(posedge clk) begin
        if (!nrst) begin
            layers <= '0;
        end else begin
            layers <= hit;
        end
    end

endmodule

//--- memGameRules.sv
//****************************************
// memory game rules and state
// select is judged at the old cursor
// loadPuzzle wins over every other input
// selects while solved are ignored
// labels in one stage should be distinct
//****************************************
`timescale 1ns/1ps

module memGameRules (
    input  logic                 clk,
    input  logic                 nrst,
    input  logic                 loadPuzzle,
    input  memGamePkg::memPuzzle puzzle,
    input  logic                 moveLeft,
    input  logic                 moveRight,
    input  logic                 select,
    output memGamePkg::memStatus status,
    output logic                 strike
);
    import memGamePkg::*;

    memPuzzle                 puzzleReg;
    memPress [numStages-1:0]  history;
    logic [2:0]               stage;
    logic [1:0]               cursor;
    logic                     solved;
    memDigit                  digit;
    memDigit [numButtons-1:0] labels;
    logic [1:0]               target;
    logic                     correct;

    // index of the button carrying a given label
    function automatic logic [1:0] findLabel(
        input memDigit [numButtons-1:0] row,
        input memDigit                  want
    );
        logic [1:0] idx;
        idx = 2'd0;
        for (int i = numButtons - 1; i >= 0; i--) begin
            if (row[i] == want) begin
                idx = 2'(i);
            end
        end
        return idx;
    endfunction

    assign digit  = puzzleReg.display[stage];
    assign labels = puzzleReg.labels[stage];

    // correct button for this stage
    always_comb begin
        target = 2'd0;
        case (stage)
            3'd0: begin
                case (digit)
                    2'd0, 2'd1: target = 2'd1;
                    2'd2:       target = 2'd2;
                    default:    target = 2'd3;
                endcase
            end
            3'd1: begin
                case (digit)
                    2'd0:    target = findLabel(labels, 2'd3);  // labelled 4
                    2'd2:    target = 2'd0;
                    default: target = history[0].position;
                endcase
            end
            3'd2: begin
                case (digit)
                    2'd0:    target = findLabel(labels, history[1].label);
                    2'd1:    target = findLabel(labels, history[0].label);
                    2'd2:    target = 2'd2;
                    default: target = findLabel(labels, 2'd3);
                endcase
            end
            3'd3: begin
                case (digit)
                    2'd0:    target = history[0].position;
                    2'd1:    target = 2'd0;
                    default: target = history[1].position;
                endcase
            end
            default: begin
                case (digit)
                    2'd0:    target = findLabel(labels, history[0].label);
                    2'd1:    target = findLabel(labels, history[1].label);
                    2'd2:    target = findLabel(labels, history[3].label);
                    default: target = findLabel(labels, history[2].label);
                endcase
            end
        endcase
    end

    assign correct = (cursor == target);

    always_ff @(posedge clk) begin
        if (!nrst) begin
            stage  <= 3'd0;
            cursor <= 2'd0;
            solved <= 1'b0;
            strike <= 1'b0;
        end else begin
            strike <= 1'b0;
            if (loadPuzzle) begin
                stage  <= 3'd0;
                cursor <= 2'd0;
                solved <= 1'b0;
            end else begin
                // cursor saturates at both ends
                if (moveLeft && !moveRight && cursor != 2'd3) begin
                    cursor <= cursor + 2'd1;
                end else if (moveRight && !moveLeft && cursor != 2'd0) begin
                    cursor <= cursor - 2'd1;
                end
                if (select && !solved) begin
                    if (!correct) begin
                        strike <= 1'b1;
                        stage  <= 3'd0;     // back to the start
                    end else if (stage == 3'(numStages - 1)) begin
                        solved <= 1'b1;     // stage stays on the last one
                    end else begin
                        stage <= stage + 3'd1;
                    end
                end
            end
        end
    end

    // puzzle and press history
    always_ff @(posedge clk) begin
        if (loadPuzzle) begin
            puzzleReg <= puzzle;
            history   <= '0;
        end else if (select && !solved && correct) begin
            history[stage] <= '{position: cursor, label: labels[cursor]};
        end
    end

    assign status = '{
        stage:       stage,
        cursor:      cursor,
        shownDigit:  digit,
        shownLabels: labels,
        solved:      solved
    };

endmodule

//--- screenPkg.sv
//****************************************
// screen geometry and colours, RGB565
// x runs to 240, y fits in 8 bits
// digits are drawn from a base corner
// with the segment offsets below
//****************************************
package screenPkg;

    localparam int screenWidth  = 240;
    localparam int buttonHeight = 90;
    localparam int buttonWidth  = 40;
    localparam int marginHeight = 20;
    localparam int marginWidth  = 25;
    localparam int space        = 10;

    localparam int labelInset = 10;     // label digit rows into the button
    localparam int ringWidth  = 5;      // highlight grows this much per side

    // lower row holds display digit and stage lights
    localparam int displayX = screenWidth - (marginWidth + buttonWidth + marginWidth);
    localparam int lowerY   = marginHeight + buttonHeight + marginHeight;

    // segment bar offsets from the digit base
    localparam int segColNear   = 10;
    localparam int segColFar    = 30;
    localparam int segRowBottom = 25;   // bar lit for 2 and 3
    localparam int segRowMid    = 45;   // bar lit for 2, 3 and 4
    localparam int segRowTop    = 65;

    typedef struct packed {
        logic       display;
        logic       button;
        logic [3:0] label;
        logic       stage;
        logic       highlight;
        logic       solvedTint;
        logic [2:0] reserved;   // always zero
    } memLayers;

    localparam logic [15:0] colBackground = 16'h0000;
    localparam logic [15:0] colButton     = 16'hBDF7;
    localparam logic [15:0] colLabel      = 16'h18E3;
    localparam logic [15:0] colDisplay    = 16'hFFFF;
    localparam logic [15:0] colStage      = 16'h07E0;
    localparam logic [15:0] colHighlight  = 16'hFFE0;
    localparam logic [15:0] colSolved     = 16'h9772;

endpackage

//--- memGamePkg.sv
//****************************************
// game state types for the memory panel
// digits are 2-bit codes, value v shows v+1
// label index 0 is the right-hand button
// one puzzle holds all five stages at once
//****************************************
package memGamePkg;

    localparam int numStages  = 5;
    localparam int numButtons = 4;

    typedef logic [1:0] memDigit;   // 0..3 shown as 1..4

    // whole puzzle, loaded in one go
    typedef struct packed {
        memDigit [numStages-1:0]                   display;
        memDigit [numStages-1:0][numButtons-1:0]   labels;
    } memPuzzle;

    // what was pressed in one stage
    typedef struct packed {
        logic [1:0] position;   // button index, 0 = right-hand
        memDigit    label;
    } memPress;

    // state handed to the pixel side
    typedef struct packed {
        logic [2:0]                 stage;
        logic [1:0]                 cursor;
        memDigit                    shownDigit;
        memDigit [numButtons-1:0]   shownLabels;
        logic                       solved;
    } memStatus;

endpackage
